/* source/ex_consts.svh */
// Execute stage constants
// Data width, execution unit count and the tag and index widths
// carried with every instruction through the integer execute stage

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// Datapath
`define XLEN          32
`define INST_BITS     32
`define SHAMT_BITS    $clog2(`XLEN)

// Execution unit pool, any count of one or more
`define NUM_EX_UNITS  4
`define UNIT_IDX_BITS ((`NUM_EX_UNITS > 1) ? $clog2(`NUM_EX_UNITS) : 1)

// Out-of-order bookkeeping
`define ROB_TAG_BITS  5
`define REG_IDX_BITS  6

`endif

/* source/rv_isa_pkg.sv */
// RV32 instruction set encodings
// ALU function codes, operand source selects and the funct3
// branch conditions used by the execute stage

package rv_isa_pkg;

    // ALU function codes
    typedef enum logic [3:0] {
        ALU_ADD  = 4'h0,
        ALU_SUB  = 4'h1,
        ALU_SLT  = 4'h2,
        ALU_SLTU = 4'h3,
        ALU_AND  = 4'h4,
        ALU_OR   = 4'h5,
        ALU_XOR  = 4'h6,
        ALU_SLL  = 4'h7,
        ALU_SRL  = 4'h8,
        ALU_SRA  = 4'h9
    } alu_func_e;

    // Operand A sources
    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_NPC  = 2'h1,
        OPA_IS_PC   = 2'h2,
        OPA_IS_ZERO = 2'h3
    } opa_select_e;

    // Operand B sources, immediates come from the instruction word
    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_select_e;

    // Branch conditions, encoded as funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_e;

endpackage

/* source/ex_stage_pkg.sv */
// Execute stage data types
// Issue packet as handed over by the issue stage, completion packet
// as it leaves the stage, and the state of one execution unit

`include "ex_consts.svh"

package ex_stage_pkg;

    typedef logic [`UNIT_IDX_BITS-1:0] unit_idx_t;

    // Instruction as it arrives from issue
    typedef struct packed {
        logic [`INST_BITS-1:0]     inst;
        logic [`XLEN-1:0]          pc;
        logic [`XLEN-1:0]          npc;
        logic [`XLEN-1:0]          rs1_value;
        logic [`XLEN-1:0]          rs2_value;
        rv_isa_pkg::opa_select_e   opa_select;
        rv_isa_pkg::opb_select_e   opb_select;
        rv_isa_pkg::alu_func_e     alu_func;
        logic                      cond_branch;
        logic                      uncond_branch;
        unit_idx_t                 unit_idx;
        logic [`ROB_TAG_BITS-1:0]  rob_tag;
        logic [`REG_IDX_BITS-1:0]  dest_reg;
    } issue_packet_t;

    // Instruction as it leaves for writeback and the ROB
    typedef struct packed {
        logic [`XLEN-1:0]          result;
        logic                      take_branch;
        logic [`ROB_TAG_BITS-1:0]  rob_tag;
        logic [`REG_IDX_BITS-1:0]  dest_reg;
    } ex_complete_t;

    // Execution unit life cycle
    typedef enum logic [1:0] {
        UNIT_IDLE = 2'h0,
        UNIT_BUSY = 2'h1,
        UNIT_DONE = 2'h2
    } unit_state_e;

endpackage

/* source/ex_unit_if.sv */
// Execution unit link
// Joins the dispatcher, one execution unit and the completion arbiter

`include "ex_consts.svh"

interface ex_unit_if;
    import rv_isa_pkg::*;

    // Dispatch side
    logic                     start;
    logic [`XLEN-1:0]         opa;
    logic [`XLEN-1:0]         opb;
    logic [`XLEN-1:0]         rs1;
    logic [`XLEN-1:0]         rs2;
    alu_func_e                func;
    branch_cond_e             cond;
    logic                     cond_branch;
    logic                     uncond_branch;
    logic [`ROB_TAG_BITS-1:0] rob_tag;
    logic [`REG_IDX_BITS-1:0] dest_reg;
    logic                     busy;

    // Result side, tags held by the unit
    logic                     result_valid;
    logic [`XLEN-1:0]         result;
    logic                     take_branch;
    logic [`ROB_TAG_BITS-1:0] res_rob_tag;
    logic [`REG_IDX_BITS-1:0] res_dest_reg;
    logic                     free;

    modport dispatch (
        output start, opa, opb, rs1, rs2, func, cond, cond_branch, uncond_branch,
        output rob_tag, dest_reg,
        input  busy
    );

    modport unit (
        input  start, opa, opb, rs1, rs2, func, cond, cond_branch, uncond_branch,
        input  rob_tag, dest_reg, free,
        output busy, result_valid, result, take_branch, res_rob_tag, res_dest_reg
    );

    modport drain (
        input  result_valid, result, take_branch, res_rob_tag, res_dest_reg,
        output free
    );

endinterface

/* source/operand_dispatch.sv */
// Operand dispatcher
// Runs the four-phase issue handshake, selects operand A and B with
// immediates decoded from the instruction word, and starts the named unit

`include "ex_consts.svh"

module operand_dispatch (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        issue_req,
    input  ex_stage_pkg::issue_packet_t issue_pkt,
    output logic                        issue_ack,
    ex_unit_if.dispatch                 units [`NUM_EX_UNITS]
);
    import rv_isa_pkg::*;
    import ex_stage_pkg::*;

    logic [`NUM_EX_UNITS-1:0] busy_vec;
    logic [`NUM_EX_UNITS-1:0] start_q;
    logic                     target_busy;
    logic                     fire;
    unit_idx_t                target;
    logic [`XLEN-1:0]         opa_mux;
    logic [`XLEN-1:0]         opb_mux;
    logic [`INST_BITS-1:0]    inst;

    // Registered operands, shared by all units
    logic [`XLEN-1:0]         opa_q;
    logic [`XLEN-1:0]         opb_q;
    logic [`XLEN-1:0]         rs1_q;
    logic [`XLEN-1:0]         rs2_q;
    alu_func_e                func_q;
    branch_cond_e             cond_q;
    logic                     cond_br_q;
    logic                     uncond_br_q;
    logic [`ROB_TAG_BITS-1:0] rob_tag_q;
    logic [`REG_IDX_BITS-1:0] dest_reg_q;

    assign inst   = issue_pkt.inst;
    assign target = issue_pkt.unit_idx;

    // Out-of-range index never gets an ack
    assign target_busy = (int'(target) < `NUM_EX_UNITS) ? busy_vec[target] : 1'b1;
    assign fire        = issue_req && !issue_ack && !target_busy;

    always_comb begin
        case (issue_pkt.opa_select)
            OPA_IS_RS1: opa_mux = issue_pkt.rs1_value;
            OPA_IS_NPC: opa_mux = issue_pkt.npc;
            OPA_IS_PC:  opa_mux = issue_pkt.pc;
            default:    opa_mux = '0;
        endcase
    end

    // RV32 immediate formats, all sign-extended from bit 31
    always_comb begin
        case (issue_pkt.opb_select)
            OPB_IS_I_IMM: opb_mux = {{(`XLEN-12){inst[31]}}, inst[31:20]};
            OPB_IS_S_IMM: opb_mux = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            OPB_IS_B_IMM: opb_mux = {{(`XLEN-13){inst[31]}}, inst[31], inst[7],
                                     inst[30:25], inst[11:8], 1'b0};
            OPB_IS_U_IMM: opb_mux = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            OPB_IS_J_IMM: opb_mux = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12],
                                     inst[20], inst[30:21], 1'b0};
            default:      opb_mux = issue_pkt.rs2_value;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Handshake and start pulse
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            issue_ack <= 1'b0;
            start_q   <= '0;
        end else begin
            start_q <= '0;
            if (fire) begin
                issue_ack <= 1'b1;
                start_q   <= `NUM_EX_UNITS'(1) << target;
            end else if (issue_ack && !issue_req) begin
                issue_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            opa_q       <= opa_mux;
            opb_q       <= opb_mux;
            rs1_q       <= issue_pkt.rs1_value;
            rs2_q       <= issue_pkt.rs2_value;
            func_q      <= issue_pkt.alu_func;
            cond_q      <= branch_cond_e'(inst[14:12]);
            cond_br_q   <= issue_pkt.cond_branch;
            uncond_br_q <= issue_pkt.uncond_branch;
            rob_tag_q   <= issue_pkt.rob_tag;
            dest_reg_q  <= issue_pkt.dest_reg;
        end
    end

    for (genvar g = 0; g < `NUM_EX_UNITS; g++) begin : g_unit
        assign busy_vec[g]             = units[g].busy;
        assign units[g].start          = start_q[g];
        assign units[g].opa            = opa_q;
        assign units[g].opb            = opb_q;
        assign units[g].rs1            = rs1_q;
        assign units[g].rs2            = rs2_q;
        assign units[g].func           = func_q;
        assign units[g].cond           = cond_q;
        assign units[g].cond_branch    = cond_br_q;
        assign units[g].uncond_branch  = uncond_br_q;
        assign units[g].rob_tag        = rob_tag_q;
        assign units[g].dest_reg       = dest_reg_q;
    end

endmodule

/* source/exec_unit.sv */
// Integer execution unit
// Computes the ALU result and the branch decision for one instruction
// and holds both, with the tags, until the completion arbiter frees it

`include "ex_consts.svh"

module exec_unit (
    input  logic      clock,
    input  logic      rst_n,
    ex_unit_if.unit   port
);
    import rv_isa_pkg::*;
    import ex_stage_pkg::*;

    unit_state_e              state;
    logic [`XLEN-1:0]         alu_out;
    logic [`SHAMT_BITS-1:0]   shamt;
    logic                     cond_true;
    logic                     accept;

    // Result hold register
    logic [`XLEN-1:0]         result_q;
    logic                     take_q;
    logic [`ROB_TAG_BITS-1:0] rob_tag_q;
    logic [`REG_IDX_BITS-1:0] dest_reg_q;

    assign shamt  = port.opb[`SHAMT_BITS-1:0];
    assign accept = (state == UNIT_IDLE) && port.start;

    ////////////////////////////////////////////////////////////
    // ALU and branch condition
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (port.func)
            ALU_ADD:  alu_out = port.opa + port.opb;
            ALU_SUB:  alu_out = port.opa - port.opb;
            ALU_SLT:  alu_out = `XLEN'($signed(port.opa) < $signed(port.opb));
            ALU_SLTU: alu_out = `XLEN'(port.opa < port.opb);
            ALU_AND:  alu_out = port.opa & port.opb;
            ALU_OR:   alu_out = port.opa | port.opb;
            ALU_XOR:  alu_out = port.opa ^ port.opb;
            ALU_SLL:  alu_out = port.opa << shamt;
            ALU_SRL:  alu_out = port.opa >> shamt;
            ALU_SRA:  alu_out = $signed(port.opa) >>> shamt;
            default:  alu_out = port.opa + port.opb;
        endcase
    end

    // Condition is on the register values, not on the operands
    always_comb begin
        case (port.cond)
            BR_EQ:   cond_true = (port.rs1 == port.rs2);
            BR_NE:   cond_true = (port.rs1 != port.rs2);
            BR_LT:   cond_true = ($signed(port.rs1) < $signed(port.rs2));
            BR_GE:   cond_true = ($signed(port.rs1) >= $signed(port.rs2));
            BR_LTU:  cond_true = (port.rs1 < port.rs2);
            BR_GEU:  cond_true = (port.rs1 >= port.rs2);
            default: cond_true = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Unit state
    ////////////////////////////////////////////////////////////

    // BUSY is the first cycle of a fresh result, DONE waits for the drain
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= UNIT_IDLE;
        end else begin
            case (state)
                UNIT_IDLE: if (accept) state <= UNIT_BUSY;
                UNIT_BUSY: state <= port.free ? UNIT_IDLE : UNIT_DONE;
                UNIT_DONE: if (port.free) state <= UNIT_IDLE;
                default:   state <= UNIT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            result_q   <= alu_out;
            take_q     <= port.uncond_branch || (port.cond_branch && cond_true);
            rob_tag_q  <= port.rob_tag;
            dest_reg_q <= port.dest_reg;
        end
    end

    assign port.busy         = (state != UNIT_IDLE);
    assign port.result_valid = (state != UNIT_IDLE);
    assign port.result       = result_q;
    assign port.take_branch  = take_q;
    assign port.res_rob_tag  = rob_tag_q;
    assign port.res_dest_reg = dest_reg_q;

endmodule

/* source/completion_arbiter.sv */
// Completion arbiter
// Drains one finished unit per cycle, lowest index first, into a
// registered completion packet and frees that unit in the same cycle

`include "ex_consts.svh"

module completion_arbiter (
    input  logic                       clock,
    input  logic                       rst_n,
    ex_unit_if.drain                   units [`NUM_EX_UNITS],
    output logic                       out_valid,
    output ex_stage_pkg::ex_complete_t out_pkt
);
    import ex_stage_pkg::*;

    logic [`NUM_EX_UNITS-1:0] valid_vec;
    logic [`NUM_EX_UNITS-1:0] free_q;
    logic [`NUM_EX_UNITS-1:0] cand;
    ex_complete_t             done_pkt [`NUM_EX_UNITS];
    logic                     pick_found;
    unit_idx_t                pick_idx;

    for (genvar g = 0; g < `NUM_EX_UNITS; g++) begin : g_unit
        assign valid_vec[g]   = units[g].result_valid;
        assign done_pkt[g]    = '{result:      units[g].result,
                                  take_branch: units[g].take_branch,
                                  rob_tag:     units[g].res_rob_tag,
                                  dest_reg:    units[g].res_dest_reg};
        assign units[g].free  = free_q[g];
    end

    // Unit being freed right now still shows valid for this cycle
    assign cand = valid_vec & ~free_q;

    always_comb begin
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int i = `NUM_EX_UNITS - 1; i >= 0; i--) begin
            if (cand[i]) begin
                pick_found = 1'b1;
                pick_idx   = unit_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            free_q    <= '0;
        end else begin
            out_valid <= pick_found;
            free_q    <= pick_found ? (`NUM_EX_UNITS'(1) << pick_idx) : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (pick_found) begin
            out_pkt <= done_pkt[pick_idx];
        end
    end

endmodule

/* source/stage_ex.sv */
// Integer execute stage
// Dispatcher, a pool of identical ALU and branch units, and the
// completion arbiter, joined by one link per unit

`include "ex_consts.svh"

module stage_ex (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        issue_req,
    input  ex_stage_pkg::issue_packet_t issue_pkt,
    output logic                        issue_ack,
    output logic                        out_valid,
    output ex_stage_pkg::ex_complete_t  out_pkt
);

    // One link per execution unit
    ex_unit_if unit_bus [`NUM_EX_UNITS] ();

    operand_dispatch u_dispatch (
        .clock     (clock),
        .rst_n     (rst_n),
        .issue_req (issue_req),
        .issue_pkt (issue_pkt),
        .issue_ack (issue_ack),
        .units     (unit_bus)
    );

    for (genvar g = 0; g < `NUM_EX_UNITS; g++) begin : g_exec
        exec_unit u_unit (
            .clock (clock),
            .rst_n (rst_n),
            .port  (unit_bus[g])
        );
    end

    completion_arbiter u_arbiter (
        .clock     (clock),
        .rst_n     (rst_n),
        .units     (unit_bus),
        .out_valid (out_valid),
        .out_pkt   (out_pkt)
    );

endmodule

/* bench/stage_ex_tb.sv */
// Execute stage testbench
// Reads instructions and their expected completions from the stimulus
// file, drives the four-phase issue handshake and checks every
// completion against a table indexed by rob tag, in any order

`include "ex_consts.svh"

module stage_ex_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import ex_stage_pkg::*;

    localparam int MAX_LINES       = 1 << `ROB_TAG_BITS;
    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_LINE = 40;
    localparam int DRAIN_CYCLES    = 4;

    logic          clock;
    logic          rst_n;
    logic          issue_req;
    issue_packet_t issue_pkt;
    logic          issue_ack;
    logic          out_valid;
    ex_complete_t  out_pkt;

    // Stimulus in file order
    issue_packet_t stim_pkt [MAX_LINES];
    int            n_lines;

    // Expected completions, indexed by rob tag
    ex_complete_t  exp_pkt  [MAX_LINES];
    logic          exp_used [MAX_LINES];
    int            exp_line [MAX_LINES];
    unit_idx_t     exp_unit [MAX_LINES];

    logic          seen [MAX_LINES] = '{default: 1'b0};
    int            n_seen = 0;
    int            issued_cnt  [`NUM_EX_UNITS] = '{default: 0};
    int            drained_cnt [`NUM_EX_UNITS] = '{default: 0};
    int            cycle_count = 0;
    int            cycle_limit;

    stage_ex dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .issue_req (issue_req),
        .issue_pkt (issue_pkt),
        .issue_ack (issue_ack),
        .out_valid (out_valid),
        .out_pkt   (out_pkt)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and compares
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "stage_ex_tb stopped at cycle %0d", cycle_count);
    endtask

    function automatic string format_completion(input ex_complete_t pkt);
        return $sformatf("result %h take %b tag %0d dest %0d",
                         pkt.result, pkt.take_branch, pkt.rob_tag, pkt.dest_reg);
    endfunction

    task automatic check_ack(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s expected %b actual %b", name, expected, actual);
            abort_run("handshake signal at the wrong level");
        end
    endtask

    task automatic check_result(input string name, input ex_complete_t expected,
                                input ex_complete_t actual);
        if (actual !== expected) begin
            $display("error %s expected %s actual %s", name,
                     format_completion(expected), format_completion(actual));
            abort_run("completion packet differs from the expected one");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus file
    ////////////////////////////////////////////////////////////

    task automatic load_stimulus();
        int                       fd;
        int                       code;
        int                       line_no;
        string                    text;
        logic [31:0]              field [15];
        logic [`ROB_TAG_BITS-1:0] tag;
        issue_packet_t            pkt;
        for (int i = 0; i < MAX_LINES; i++) begin
            exp_used[i] = 1'b0;
        end
        n_lines = 0;
        line_no = 0;
        fd = $fopen("bench/ex_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/ex_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(text, fd);
                line_no++;
                if (code > 0) begin
                    // Comment and blank lines give fewer than 15 fields
                    code = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   field[0], field[1], field[2], field[3], field[4],
                                   field[5], field[6], field[7], field[8], field[9],
                                   field[10], field[11], field[12], field[13], field[14]);
                    tag = field[11][`ROB_TAG_BITS-1:0];
                    if (code != 15) begin
                        continue;
                    end else if (n_lines == MAX_LINES) begin
                        abort_run("stimulus file holds more lines than rob tags");
                    end else if (exp_used[tag]) begin
                        abort_run($sformatf("stimulus line %0d repeats rob tag %0d",
                                            line_no, tag));
                    end else begin
                        pkt.inst          = field[0];
                        pkt.pc            = field[1];
                        pkt.npc           = field[2];
                        pkt.rs1_value     = field[3];
                        pkt.rs2_value     = field[4];
                        pkt.opa_select    = opa_select_e'(field[5][1:0]);
                        pkt.opb_select    = opb_select_e'(field[6][2:0]);
                        pkt.alu_func      = alu_func_e'(field[7][3:0]);
                        pkt.cond_branch   = field[8][0];
                        pkt.uncond_branch = field[9][0];
                        pkt.unit_idx      = field[10][`UNIT_IDX_BITS-1:0];
                        pkt.rob_tag       = tag;
                        pkt.dest_reg      = field[12][`REG_IDX_BITS-1:0];
                        stim_pkt[n_lines] = pkt;
                        exp_pkt[tag].result      = field[13];
                        exp_pkt[tag].take_branch = field[14][0];
                        exp_pkt[tag].rob_tag     = tag;
                        exp_pkt[tag].dest_reg    = pkt.dest_reg;
                        exp_line[tag] = line_no;
                        exp_unit[tag] = pkt.unit_idx;
                        exp_used[tag] = 1'b1;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
            if (n_lines == 0) begin
                abort_run("stimulus file holds no instructions");
            end
        end
    endtask

    // One four-phase handshake after a random idle gap
    task automatic drive_request(input int idx);
        int unsigned gap;
        unit_idx_t   unit;
        gap  = $urandom % 4;
        unit = stim_pkt[idx].unit_idx;
        repeat (gap) @(posedge clock);
        @(posedge clock);
        issue_pkt <= stim_pkt[idx];
        issue_req <= 1'b1;
        @(negedge clock);
        while (issue_ack !== 1'b1) @(negedge clock);
        // All earlier work of this unit must have left the stage
        check_ack($sformatf("request %0d acked only for an idle unit", idx),
                  1'b1, logic'(issued_cnt[unit] == drained_cnt[unit]));
        issued_cnt[unit]++;
        @(posedge clock);
        issue_req <= 1'b0;
        @(negedge clock);
        while (issue_ack !== 1'b0) @(negedge clock);
    endtask

    ////////////////////////////////////////////////////////////
    // Completion monitor and cycle limit
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin : watch_completions
        logic [`ROB_TAG_BITS-1:0] tag;
        if (rst_n === 1'b1 && out_valid === 1'b1) begin
            tag = out_pkt.rob_tag;
            if (!exp_used[tag]) begin
                abort_run($sformatf("completion carries unknown rob tag %0d", tag));
            end else if (seen[tag]) begin
                abort_run($sformatf("rob tag %0d completed twice", tag));
            end else begin
                check_result($sformatf("line %0d tag %0d", exp_line[tag], tag),
                             exp_pkt[tag], out_pkt);
                seen[tag] = 1'b1;
                drained_cnt[exp_unit[tag]]++;
                n_seen++;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d completions",
                                cycle_count, n_seen, n_lines));
        end
    end

    initial begin
        issue_req   = 1'b0;
        issue_pkt   = '0;
        rst_n       = 1'b0;
        cycle_limit = RESET_CYCLES + CYCLES_PER_LINE;
        void'($urandom(32'ha155_3316));
        load_stimulus();
        cycle_limit = RESET_CYCLES + DRAIN_CYCLES + CYCLES_PER_LINE * n_lines;

        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_ack("reset issue_ack", 1'b0, issue_ack);
        check_ack("reset out_valid", 1'b0, out_valid);

        for (int i = 0; i < n_lines; i++) begin
            drive_request(i);
        end

        while (n_seen < n_lines) @(negedge clock);
        // Any stray completion shows up in the monitor
        repeat (DRAIN_CYCLES) @(negedge clock);
        @(posedge clock);
        $display("Test OK");
        $finish;
    end

endmodule

/* src.f */
+incdir+source
source/rv_isa_pkg.sv
source/ex_stage_pkg.sv
source/ex_unit_if.sv
source/operand_dispatch.sv
source/exec_unit.sv
source/completion_arbiter.sv
source/stage_ex.sv
bench/stage_ex_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

TOOL     = verilator
TOP      = stage_ex_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/ex_stimulus.txt */
// inst pc npc rs1 rs2 opa_sel opb_sel alu_func cond uncond unit rob_tag dest
// then expected result and take_branch, all fields hex
// ALU with register operand B
00000033 00001000 00001004 00000005 00000007 0 0 0 0 0 0 00 01 0000000c 0
40000033 00001000 00001004 00000003 00000005 0 0 1 0 0 1 01 02 fffffffe 0
00002033 00001000 00001004 ffffffff 00000001 0 0 2 0 0 2 02 03 00000001 0
00003033 00001000 00001004 ffffffff 00000001 0 0 3 0 0 3 03 04 00000000 0
00007033 00001000 00001004 f0f0f0f0 ff00ff00 0 0 4 0 0 0 04 05 f000f000 0
00006033 00001000 00001004 f0f0f0f0 0f0f0000 0 0 5 0 0 1 05 06 fffff0f0 0
00004033 00001000 00001004 aaaaaaaa ffff0000 0 0 6 0 0 2 06 07 5555aaaa 0
00001033 00001000 00001004 00000001 0000001f 0 0 7 0 0 3 07 08 80000000 0
00005033 00001000 00001004 80000000 00000024 0 0 8 0 0 0 08 09 08000000 0
40005033 00001000 00001004 80000000 00000004 0 0 9 0 0 1 09 0a f8000000 0
// Operand A from PC, NPC and zero
00000033 00001000 00001004 12345678 00000010 2 0 0 0 0 2 0a 0b 00001010 0
00000033 00001000 00001004 12345678 00000008 1 0 0 0 0 3 0b 0c 0000100c 0
40000033 00001000 00001004 00000009 00000001 3 0 1 0 0 0 0c 0d ffffffff 0
// I, S, U and J immediates
fff00093 00001000 00001004 00000010 00000000 0 1 0 0 0 1 0d 0e 0000000f 0
7ff00093 00001000 00001004 00001000 00000000 0 1 5 0 0 2 0e 0f 000017ff 0
fe20ae23 00001000 00001004 00002000 00000000 0 2 0 0 0 3 0f 10 00001ffc 0
0020aa23 00001000 00001004 00000100 00000000 0 2 0 0 0 0 10 11 00000114 0
800010b7 00001000 00001004 00000000 00000000 3 4 0 0 0 1 11 12 80001000 0
12345097 00001000 00001004 00000000 00000000 2 4 0 0 0 2 12 13 12346000 0
ff9ff0ef 00002000 00002004 00000000 00000000 2 5 0 0 1 3 13 14 00001ff8 1
0010006f 00003000 00003004 00000000 00000000 2 5 0 0 1 0 14 15 00003800 1
// Conditional branches, target is PC plus B immediate
00208863 00001000 00001004 00000007 00000007 2 3 0 1 0 1 15 00 00001010 1
00209863 00001000 00001004 00000007 00000007 2 3 0 1 0 2 16 00 00001010 0
fe20c8e3 00004000 00004004 ffffffff 00000001 2 3 0 1 0 3 17 00 00003ff0 1
fe20d8e3 00004000 00004004 ffffffff 00000001 2 3 0 1 0 0 18 00 00003ff0 0
fe20e8e3 00005000 00005004 ffffffff 00000001 2 3 0 1 0 1 19 00 00004ff0 0
fe20f8e3 00005000 00005004 ffffffff 00000001 2 3 0 1 0 2 1a 00 00004ff0 1
00209863 00001000 00001004 00000005 00000006 2 3 0 1 0 3 1b 00 00001010 1
// Back to back requests to unit 0
00000033 00001000 00001004 00000001 00000002 0 0 0 0 0 0 1c 1c 00000003 0
00000033 00001000 00001004 00000010 00000020 0 0 0 0 0 0 1d 1d 00000030 0
40000033 00001000 00001004 00000100 00000001 0 0 1 0 0 0 1e 1e 000000ff 0
